//--- files.f
+incdir+src
src/core_pkg.sv
src/alu.sv
src/idu.sv
src/exu.sv
src/lsu.sv
src/exec_top.sv
test/exec_properties.sv
test/exec_checker.sv
test/exec_tb.sv

//--- run.sh
#!/bin/sh
# build and run the exec_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module exec_tb -f files.f -o exec_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/exec_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

//--- src/alu.sv
module alu (
  input  core_pkg::word_t   src1,
  input  core_pkg::word_t   src2,
  input  core_pkg::alu_op_e alu_op,
  output core_pkg::word_t   alu_res
);

  logic [4:0] shamt;
  logic lt_s, lt_u, eq;

  assign shamt = src2[4:0];
  assign lt_s = $signed(src1) < $signed(src2);
  assign lt_u = src1 < src2;
  assign eq = src1 == src2;

  always_comb begin
    case (alu_op)
      core_pkg::ALU_ADD:    alu_res = src1 + src2;
      core_pkg::ALU_SUB:    alu_res = src1 - src2;
      core_pkg::ALU_SLL:    alu_res = src1 << shamt;
      core_pkg::ALU_SRL:    alu_res = src1 >> shamt;
      core_pkg::ALU_SRA:    alu_res = core_pkg::word_t'($signed(src1) >>> shamt);
      core_pkg::ALU_XOR:    alu_res = src1 ^ src2;
      core_pkg::ALU_OR:     alu_res = src1 | src2;
      core_pkg::ALU_AND:    alu_res = src1 & src2;
      core_pkg::ALU_PASS_B: alu_res = src2;
      // compares land in bit 0
      core_pkg::ALU_SLT,
      core_pkg::ALU_LT:     alu_res = core_pkg::word_t'(lt_s);
      core_pkg::ALU_SLTU,
      core_pkg::ALU_LTU:    alu_res = core_pkg::word_t'(lt_u);
      core_pkg::ALU_GE:     alu_res = core_pkg::word_t'(!lt_s);
      core_pkg::ALU_GEU:    alu_res = core_pkg::word_t'(!lt_u);
      core_pkg::ALU_EQ:     alu_res = core_pkg::word_t'(eq);
      core_pkg::ALU_NE:     alu_res = core_pkg::word_t'(!eq);
      default:              alu_res = '0;
    endcase
  end

endmodule

//--- src/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [2:0] funct3_t;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,  // lui
    ALU_EQ,      // branch compares
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {IDLE, EXEC, WAIT} fsm_e;

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_IMM    = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_REG    = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

endpackage

//--- src/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and address width
`define XLEN 32

// data memory depth in words, word address taken from bits 7:2
`define MEM_WORDS 64

// cycles a load or store occupies the lsu, at least 2
`define MEM_LATENCY 3

`endif

//--- src/exec_top.sv
module exec_top (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  output logic                in_ready,
  input  core_pkg::word_t     in_inst,
  input  core_pkg::word_t     in_pc,
  input  core_pkg::word_t     in_rs1_data,
  input  core_pkg::word_t     in_rs2_data,
  output logic                out_valid,
  output core_pkg::word_t     out_pc,
  output core_pkg::word_t     out_next_pc,
  output core_pkg::reg_addr_t out_rd_addr,
  output logic                out_wb,
  output core_pkg::word_t     out_wdata
);

  // decode to execute
  logic idu_valid, exu_ready;
  core_pkg::word_t id_pc, id_dnpc, id_src1, id_src2, id_sdata;
  core_pkg::alu_op_e id_alu_op;
  core_pkg::reg_addr_t id_rd_addr;
  core_pkg::funct3_t id_funct3;
  logic id_load, id_store, id_wb, id_jump, id_branch;

  // execute to load/store
  logic exu_valid, lsu_ready;
  core_pkg::word_t ex_pc, ex_dnpc, ex_alu_res, ex_sdata;
  core_pkg::reg_addr_t ex_rd_addr;
  logic ex_load, ex_store, ex_wb, ex_jump, ex_branch;

  idu u_idu (
    .clock, .reset, .in_valid, .in_ready,
    .inst(in_inst), .pc(in_pc), .rs1_data(in_rs1_data), .rs2_data(in_rs2_data),
    .exu_ready, .idu_valid,
    .out_pc(id_pc), .dnpc(id_dnpc), .alu_src1(id_src1), .alu_src2(id_src2),
    .sdata(id_sdata), .alu_op(id_alu_op), .rd_addr(id_rd_addr), .funct3(id_funct3),
    .load(id_load), .store(id_store), .wb(id_wb), .jump(id_jump), .branch(id_branch)
  );

  exu u_exu (
    .clock, .reset, .idu_valid, .exu_ready,
    .idu_pc(id_pc), .idu_dnpc(id_dnpc), .idu_alu_src1(id_src1), .idu_alu_src2(id_src2),
    .idu_alu_op(id_alu_op), .idu_sdata(id_sdata), .idu_rd_addr(id_rd_addr),
    .idu_funct3(id_funct3), .idu_load(id_load), .idu_store(id_store), .idu_wb(id_wb),
    .idu_jump(id_jump), .idu_branch(id_branch),
    .lsu_ready, .exu_valid,
    .pc(ex_pc), .dnpc(ex_dnpc), .alu_res(ex_alu_res), .sdata(ex_sdata),
    .rd_addr(ex_rd_addr), .load(ex_load), .store(ex_store), .wb(ex_wb),
    .jump(ex_jump), .branch(ex_branch)
  );

  lsu u_lsu (
    .clock, .reset, .exu_valid, .lsu_ready,
    .pc(ex_pc), .dnpc(ex_dnpc), .alu_res(ex_alu_res), .sdata(ex_sdata),
    .rd_addr(ex_rd_addr), .load(ex_load), .store(ex_store), .wb(ex_wb),
    .jump(ex_jump), .branch(ex_branch),
    .out_valid, .out_pc, .out_next_pc, .out_wdata, .out_rd_addr, .out_wb
  );

endmodule

//--- src/exu.sv
module exu (
  input  logic                clock,
  input  logic                reset,
  input  logic                idu_valid,
  output logic                exu_ready,
  input  core_pkg::word_t     idu_pc,
  input  core_pkg::word_t     idu_dnpc,
  input  core_pkg::word_t     idu_alu_src1,
  input  core_pkg::word_t     idu_alu_src2,
  input  core_pkg::alu_op_e   idu_alu_op,
  input  core_pkg::word_t     idu_sdata,
  input  core_pkg::reg_addr_t idu_rd_addr,
  input  core_pkg::funct3_t   idu_funct3,
  input  logic                idu_load,
  input  logic                idu_store,
  input  logic                idu_wb,
  input  logic                idu_jump,
  input  logic                idu_branch,
  input  logic                lsu_ready,
  output logic                exu_valid,
  output core_pkg::word_t     pc,
  output core_pkg::word_t     dnpc,
  output core_pkg::word_t     alu_res,
  output core_pkg::word_t     sdata,
  output core_pkg::reg_addr_t rd_addr,
  output logic                load,
  output logic                store,
  output logic                wb,
  output logic                jump,
  output logic                branch
);

  core_pkg::fsm_e curr, next;
  core_pkg::word_t alu_out;
  logic capture, taken, word_acc, bad_acc;

  always_ff @(posedge clock) begin
    if (reset) curr <= core_pkg::IDLE;
    else curr <= next;
  end

  always_comb begin
    case (curr)
      core_pkg::IDLE: next = idu_valid ? core_pkg::EXEC : core_pkg::IDLE;
      default: next = lsu_ready ? core_pkg::IDLE : core_pkg::WAIT;  // exec or wait
    endcase
  end

  // ready and valid registered alongside the state
  always_ff @(posedge clock) begin
    if (reset) begin
      exu_ready <= 1'b1;
      exu_valid <= 1'b0;
    end else if (curr == core_pkg::IDLE) begin
      exu_ready <= !idu_valid;
      exu_valid <= idu_valid;
    end else begin
      exu_ready <= lsu_ready;
      exu_valid <= !lsu_ready;
    end
  end

  alu u_alu (
    .src1   (idu_alu_src1),
    .src2   (idu_alu_src2),
    .alu_op (idu_alu_op),
    .alu_res(alu_out)
  );

  assign capture = (curr == core_pkg::IDLE) && idu_valid;
  assign taken = idu_branch & alu_out[0];
  assign word_acc = (idu_funct3 == 3'b010);  // only lw and sw
  assign bad_acc = (idu_load | idu_store) & !word_acc;

  always_ff @(posedge clock) begin
    if (capture) begin
      pc <= idu_pc;
      dnpc <= idu_dnpc;
      alu_res <= alu_out;
      sdata <= idu_sdata;
      rd_addr <= idu_rd_addr;
      load <= idu_load & word_acc;
      store <= idu_store & word_acc;
      wb <= idu_wb & !bad_acc;  // sub-word access becomes a nop
      jump <= idu_jump;
      branch <= taken;
    end
  end

endmodule

//--- src/idu.sv
module idu (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  output logic                in_ready,
  input  core_pkg::word_t     inst,
  input  core_pkg::word_t     pc,
  input  core_pkg::word_t     rs1_data,
  input  core_pkg::word_t     rs2_data,
  input  logic                exu_ready,
  output logic                idu_valid,
  output core_pkg::word_t     out_pc,
  output core_pkg::word_t     dnpc,
  output core_pkg::word_t     alu_src1,
  output core_pkg::word_t     alu_src2,
  output core_pkg::word_t     sdata,
  output core_pkg::alu_op_e   alu_op,
  output core_pkg::reg_addr_t rd_addr,
  output core_pkg::funct3_t   funct3,
  output logic                load,
  output logic                store,
  output logic                wb,
  output logic                jump,
  output logic                branch
);

  core_pkg::fsm_e state, next;
  core_pkg::opcode_e opcode;
  core_pkg::funct3_t f3;
  core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j, jalr_tgt;
  core_pkg::word_t d_src1, d_src2, d_dnpc;
  core_pkg::alu_op_e d_op;
  logic d_load, d_store, d_wb, d_jump, d_branch;
  logic capture;

  // shared by OP and OP-IMM, alt is inst[30]
  function automatic core_pkg::alu_op_e arith_op(core_pkg::funct3_t f, logic alt, logic is_reg);
    case (f)
      3'b000:  return (alt && is_reg) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b001:  return core_pkg::ALU_SLL;
      3'b010:  return core_pkg::ALU_SLT;
      3'b011:  return core_pkg::ALU_SLTU;
      3'b100:  return core_pkg::ALU_XOR;
      3'b101:  return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  return core_pkg::ALU_OR;
      default: return core_pkg::ALU_AND;
    endcase
  endfunction

  function automatic core_pkg::alu_op_e branch_op(core_pkg::funct3_t f);
    case (f)
      3'b001:  return core_pkg::ALU_NE;
      3'b100:  return core_pkg::ALU_LT;
      3'b101:  return core_pkg::ALU_GE;
      3'b110:  return core_pkg::ALU_LTU;
      3'b111:  return core_pkg::ALU_GEU;
      default: return core_pkg::ALU_EQ;
    endcase
  endfunction

  assign opcode = core_pkg::opcode_e'(inst[6:0]);
  assign f3 = inst[14:12];
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign jalr_tgt = rs1_data + imm_i;

  always_comb begin
    d_src1 = rs1_data;
    d_src2 = rs2_data;
    d_op = core_pkg::ALU_ADD;
    d_dnpc = pc + imm_b;
    {d_load, d_store, d_wb, d_jump, d_branch} = '0;  // unknown opcode retires as a nop
    case (opcode)
      core_pkg::OPC_REG: begin
        d_op = arith_op(f3, inst[30], 1'b1);
        d_wb = 1'b1;
      end
      core_pkg::OPC_IMM: begin
        d_src2 = imm_i;
        d_op = arith_op(f3, inst[30], 1'b0);
        d_wb = 1'b1;
      end
      core_pkg::OPC_LUI: begin
        d_src2 = imm_u;
        d_op = core_pkg::ALU_PASS_B;
        d_wb = 1'b1;
      end
      core_pkg::OPC_AUIPC: begin
        d_src1 = pc;
        d_src2 = imm_u;
        d_wb = 1'b1;
      end
      core_pkg::OPC_JAL, core_pkg::OPC_JALR: begin
        d_src1 = pc;  // link address
        d_src2 = core_pkg::word_t'(4);
        d_dnpc = (opcode == core_pkg::OPC_JAL) ? pc + imm_j : {jalr_tgt[31:1], 1'b0};
        d_wb = 1'b1;
        d_jump = 1'b1;
      end
      core_pkg::OPC_BRANCH: begin
        d_op = branch_op(f3);
        d_branch = (f3[2:1] != 2'b01);  // 010 and 011 are not branches
      end
      core_pkg::OPC_LOAD: begin
        d_src2 = imm_i;
        d_load = 1'b1;
        d_wb = 1'b1;
      end
      core_pkg::OPC_STORE: begin
        d_src2 = imm_s;
        d_store = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) state <= core_pkg::IDLE;
    else state <= next;
  end

  always_comb begin
    case (state)
      core_pkg::IDLE: next = in_valid ? core_pkg::EXEC : core_pkg::IDLE;
      core_pkg::EXEC: next = exu_ready ? core_pkg::IDLE : core_pkg::EXEC;
      default: next = core_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      in_ready <= 1'b1;
      idu_valid <= 1'b0;
    end else begin
      in_ready <= (next == core_pkg::IDLE);
      idu_valid <= (next == core_pkg::EXEC);
    end
  end

  assign capture = (state == core_pkg::IDLE) && in_valid;

  always_ff @(posedge clock) begin
    if (capture) begin
      out_pc <= pc;
      dnpc <= d_dnpc;
      alu_src1 <= d_src1;
      alu_src2 <= d_src2;
      alu_op <= d_op;
      sdata <= rs2_data;
      rd_addr <= inst[11:7];
      funct3 <= f3;
      {load, store, wb, jump, branch} <= {d_load, d_store, d_wb, d_jump, d_branch};
    end
  end

endmodule

//--- src/lsu.sv
`include "core_settings.svh"

module lsu (
  input  logic                clock,
  input  logic                reset,
  input  logic                exu_valid,
  output logic                lsu_ready,
  input  core_pkg::word_t     pc,
  input  core_pkg::word_t     dnpc,
  input  core_pkg::word_t     alu_res,
  input  core_pkg::word_t     sdata,
  input  core_pkg::reg_addr_t rd_addr,
  input  logic                load,
  input  logic                store,
  input  logic                wb,
  input  logic                jump,
  input  logic                branch,
  output logic                out_valid,
  output core_pkg::word_t     out_pc,
  output core_pkg::word_t     out_next_pc,
  output core_pkg::word_t     out_wdata,
  output core_pkg::reg_addr_t out_rd_addr,
  output logic                out_wb
);

  localparam int AW = $clog2(`MEM_WORDS);
  localparam int CW = $clog2(`MEM_LATENCY) + 1;

  core_pkg::word_t mem [`MEM_WORDS];
  core_pkg::word_t st_data;
  logic [AW-1:0] mem_addr;
  logic [CW-1:0] wait_cnt;
  logic is_load, is_store;
  logic capture, retire_mem;

  assign capture = exu_valid && lsu_ready;
  assign retire_mem = !lsu_ready && (wait_cnt == CW'(1));

  always_ff @(posedge clock) begin
    if (reset) begin
      lsu_ready <= 1'b1;
      out_valid <= 1'b0;
      wait_cnt <= '0;
    end else begin
      out_valid <= 1'b0;  // strobe
      if (capture) begin
        if (load || store) begin
          lsu_ready <= 1'b0;
          wait_cnt <= CW'(`MEM_LATENCY - 1);
        end else begin
          out_valid <= 1'b1;
        end
      end else if (retire_mem) begin
        lsu_ready <= 1'b1;
        out_valid <= 1'b1;
      end else if (!lsu_ready) begin
        wait_cnt <= wait_cnt - CW'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      out_pc <= pc;
      out_next_pc <= (jump || branch) ? dnpc : pc + core_pkg::word_t'(4);
      out_rd_addr <= rd_addr;
      out_wb <= wb;
      out_wdata <= alu_res;
      mem_addr <= alu_res[AW+1:2];  // word index
      st_data <= sdata;
      is_load <= load;
      is_store <= store;
    end else if (retire_mem && is_load) begin
      out_wdata <= mem[mem_addr];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `MEM_WORDS; i++) mem[i] <= '0;
    end else if (retire_mem && is_store) begin
      mem[mem_addr] <= st_data;
    end
  end

endmodule

//--- test/exec_checker.sv
`include "core_settings.svh"

module exec_checker (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  input  logic                in_ready,
  input  core_pkg::word_t     in_inst,
  input  core_pkg::word_t     in_pc,
  input  core_pkg::word_t     in_rs1_data,
  input  core_pkg::word_t     in_rs2_data,
  input  logic                out_valid,
  input  core_pkg::word_t     out_pc,
  input  core_pkg::word_t     out_next_pc,
  input  core_pkg::reg_addr_t out_rd_addr,
  input  logic                out_wb,
  input  core_pkg::word_t     out_wdata,
  output int                  mismatches,
  output int                  late_count,
  output int                  retired
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int AW = $clog2(`MEM_WORDS);

  typedef struct packed {
    core_pkg::word_t     pc;
    core_pkg::word_t     next_pc;
    core_pkg::reg_addr_t rd;
    logic                wb;
    core_pkg::word_t     wdata;
    logic                mem;
  } retire_t;

  core_pkg::word_t model_mem [`MEM_WORDS];
  retire_t pending[$];
  int accept_cycle[$];
  logic timed[$];  // accepted into an empty pipeline
  int cycle;

  function automatic core_pkg::word_t sext(logic [31:0] v, int bits);
    return core_pkg::word_t'($signed(v << (32 - bits)) >>> (32 - bits));
  endfunction

  // expected retirement record from the RV32I rules
  function automatic retire_t predict_retire(core_pkg::word_t inst, core_pkg::word_t pc,
                                             core_pkg::word_t a, core_pkg::word_t b);
    retire_t r;
    core_pkg::word_t imm_i, imm_s, imm_b, imm_j, imm_u, addr;
    logic taken;
    imm_i = sext(inst >> 20, 12);
    imm_s = sext({20'b0, inst[31:25], inst[11:7]}, 12);
    imm_b = sext({19'b0, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}, 13);
    imm_j = sext({11'b0, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}, 21);
    imm_u = {inst[31:12], 12'b0};
    r = '{pc: pc, next_pc: pc + 4, rd: inst[11:7], wb: 1'b0, wdata: '0, mem: 1'b0};
    taken = 1'b0;
    case (inst[6:0])
      core_pkg::OPC_REG, core_pkg::OPC_IMM: begin
        if (!inst[5]) b = imm_i;  // op-imm
        r.wb = 1'b1;
        case (inst[14:12])
          3'd0: r.wdata = (inst[5] && inst[30]) ? a - b : a + b;
          3'd1: r.wdata = a << b[4:0];
          3'd2: r.wdata = core_pkg::word_t'($signed(a) < $signed(b));
          3'd3: r.wdata = core_pkg::word_t'(a < b);
          3'd4: r.wdata = a ^ b;
          3'd5: r.wdata = inst[30] ? core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6: r.wdata = a | b;
          default: r.wdata = a & b;
        endcase
      end
      core_pkg::OPC_LUI: begin
        r.wb = 1'b1;
        r.wdata = imm_u;
      end
      core_pkg::OPC_AUIPC: begin
        r.wb = 1'b1;
        r.wdata = pc + imm_u;
      end
      core_pkg::OPC_JAL, core_pkg::OPC_JALR: begin
        r.wb = 1'b1;
        r.wdata = pc + 4;
        r.next_pc = inst[3] ? pc + imm_j : (a + imm_i) & ~32'h1;
      end
      core_pkg::OPC_BRANCH: begin
        case (inst[14:12])
          3'd0: taken = a == b;
          3'd1: taken = a != b;
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          3'd7: taken = a >= b;
          default: taken = 1'b0;
        endcase
        if (taken) r.next_pc = pc + imm_b;
      end
      core_pkg::OPC_LOAD: begin
        addr = a + imm_i;
        r.wb = 1'b1;
        r.mem = 1'b1;
        r.wdata = model_mem[addr[AW+1:2]];
      end
      core_pkg::OPC_STORE: begin
        addr = a + imm_s;
        r.mem = 1'b1;
        model_mem[addr[AW+1:2]] = b;
      end
      default: ;  // anything else is a nop
    endcase
    return r;
  endfunction

  // both handshakes watched at the falling edge
  always @(negedge clock) begin
    retire_t want;
    int lat;
    logic was_timed;
    if (reset) begin
      for (int i = 0; i < `MEM_WORDS; i++) model_mem[i] = '0;
      pending.delete();
      accept_cycle.delete();
      timed.delete();
      {mismatches, late_count, retired, cycle} = '0;
    end else begin
      cycle++;
      if (out_valid) begin
        retired++;
        if (pending.size() == 0) begin
          mismatches++;
          $display("ERR %0t: out_valid with nothing in flight, pc %h", $time, out_pc);
        end else begin
          want = pending.pop_front();
          lat = cycle - accept_cycle.pop_front();
          was_timed = timed.pop_front();
          if (out_pc !== want.pc || out_next_pc !== want.next_pc || out_wb !== want.wb ||
              (want.wb && (out_rd_addr !== want.rd || out_wdata !== want.wdata))) begin
            mismatches++;
            $display("ERR %0t: pc %h/%h next %h/%h wb %b/%b rd %0d/%0d wdata %h/%h",
                     $time, out_pc, want.pc, out_next_pc, want.next_pc, out_wb, want.wb,
                     out_rd_addr, want.rd, out_wdata, want.wdata);
          end
          if (was_timed && lat != (want.mem ? `MEM_LATENCY + 2 : 3)) begin
            late_count++;
            $display("ERR %0t: pc %h retired after %0d cycles", $time, want.pc, lat);
          end
        end
      end
      if (in_valid && in_ready) begin
        timed.push_back(pending.size() == 0);
        accept_cycle.push_back(cycle);
        pending.push_back(predict_retire(in_inst, in_pc, in_rs1_data, in_rs2_data));
      end
    end
  end

endmodule

//--- test/exec_properties.sv
module exec_properties (
  input logic                clock,
  input logic                reset,
  input logic                in_valid,
  input logic                in_ready,
  input logic                out_valid,
  input logic                exu_valid,
  input logic                lsu_ready,
  input core_pkg::word_t     ex_pc,
  input core_pkg::word_t     ex_dnpc,
  input core_pkg::word_t     ex_alu_res,
  input core_pkg::word_t     ex_sdata,
  input core_pkg::reg_addr_t ex_rd_addr,
  input logic                ex_load,
  input logic                ex_store,
  input logic                ex_wb,
  input logic                ex_jump,
  input logic                ex_branch
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;  // read by the testbench top

  // exu output waits for the lsu unchanged
  exu_hold: assert property (@(posedge clock) disable iff (reset)
    exu_valid && !lsu_ready |=> exu_valid &&
      $stable({ex_pc, ex_dnpc, ex_alu_res, ex_sdata, ex_rd_addr,
               ex_load, ex_store, ex_wb, ex_jump, ex_branch}))
  else begin
    $error("exu output dropped or changed before the lsu took it");
    fail_count++;
  end

  out_quiet: assert property (@(posedge clock) reset |=> !out_valid)
  else begin
    $error("out_valid high during or right after reset");
    fail_count++;
  end

  in_busy: assert property (@(posedge clock) disable iff (reset)
    in_valid && in_ready |=> !in_ready)
  else begin
    $error("in_ready still high the cycle after a transfer");
    fail_count++;
  end

endmodule

bind exec_top exec_properties props_i (
  .clock, .reset, .in_valid, .in_ready, .out_valid, .exu_valid, .lsu_ready,
  .ex_pc, .ex_dnpc, .ex_alu_res, .ex_sdata, .ex_rd_addr,
  .ex_load, .ex_store, .ex_wb, .ex_jump, .ex_branch
);

//--- test/exec_tb.sv
`include "core_settings.svh"

module exec_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_INST = 400;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_CYCLES = NUM_INST * (`MEM_LATENCY + 6) + RESET_CYCLES;

  logic clock, reset, in_valid, in_ready, out_valid, out_wb;
  core_pkg::word_t in_inst, in_pc, in_rs1_data, in_rs2_data;
  core_pkg::word_t out_pc, out_next_pc, out_wdata;
  core_pkg::reg_addr_t out_rd_addr;
  int mismatches, late_count, retired, cycles, gap;
  logic [31:0] seed;
  core_pkg::word_t last_addr, inst, pc, rs1, rs2;

  exec_top dut_i (
    .clock, .reset, .in_valid, .in_ready, .in_inst, .in_pc, .in_rs1_data, .in_rs2_data,
    .out_valid, .out_pc, .out_next_pc, .out_rd_addr, .out_wb, .out_wdata
  );

  exec_checker checker_i (
    .clock, .reset, .in_valid, .in_ready, .in_inst, .in_pc, .in_rs1_data, .in_rs2_data,
    .out_valid, .out_pc, .out_next_pc, .out_rd_addr, .out_wb, .out_wdata,
    .mismatches, .late_count, .retired
  );

  function automatic logic [31:0] rand32();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  task automatic make_inst(output core_pkg::word_t inst, output core_pkg::word_t pc,
                           output core_pkg::word_t rs1, output core_pkg::word_t rs2);
    logic [31:0] r, f;
    logic [2:0] f3;
    logic [11:0] imm;
    core_pkg::word_t addr;
    int kind;
    kind = int'(rand32() % 11);
    r = rand32();
    f = rand32();
    pc = rand32() & 32'hffff_fffc;
    rs1 = rand32();
    rs2 = (f[4] && f[5]) ? rs1 : rand32();  // equal operands now and then
    f3 = f[10:8];
    imm = {{4{f[21]}}, f[21:16], 2'b00};  // word offset, either sign
    addr = (f[31:22] % `MEM_WORDS) * 4;
    case (kind)
      0: inst = {1'b0, r[30] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, r[24:15], f3, r[11:7],
                 7'b0110011};
      1: begin
        if (f3 == 3'd1) r[31:25] = 7'b0;
        if (f3 == 3'd5) r[31:25] = {1'b0, r[30], 5'b0};  // srli or srai
        inst = {r[31:15], f3, r[11:7], 7'b0010011};
      end
      2: inst = {r[31:7], 7'b0110111};
      3: inst = {r[31:7], 7'b0010111};
      4: inst = {r[31:7], 7'b1101111};
      5: inst = {r[31:15], 3'b000, r[11:7], 7'b1100111};
      6, 7: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;
        inst = {r[31:15], f3, r[11:7], 7'b1100011};
      end
      8: begin
        if (f[0]) addr = last_addr;  // read back the last store
        rs1 = addr - core_pkg::word_t'($signed(imm));
        inst = {imm, r[19:15], 3'b010, r[11:7], 7'b0000011};
      end
      9: begin
        rs1 = addr - core_pkg::word_t'($signed(imm));
        inst = {imm[11:5], r[24:15], 3'b010, imm[4:0], 7'b0100011};
        last_addr = addr;
      end
      default: inst = {r[31:7], 7'b0001111};  // fence, unsupported
    endcase
  endtask

  // called 2 ns after an edge, returns 2 ns after the accepting edge
  task automatic send_inst(input core_pkg::word_t inst, input core_pkg::word_t pc,
                           input core_pkg::word_t rs1, input core_pkg::word_t rs2);
    logic taken;
    in_inst = inst;
    in_pc = pc;
    in_rs1_data = rs1;
    in_rs2_data = rs2;
    in_valid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      taken = in_ready;
      @(posedge clock);
      #2;
    end
    in_valid = 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: only %0d of %0d instructions retired in %0d cycles",
             retired, NUM_INST, cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    seed = 32'd85809;
    last_addr = '0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_inst = '0;
    in_pc = '0;
    in_rs1_data = '0;
    in_rs2_data = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b0;
    repeat (5) begin  // idle, nothing may retire yet
      @(posedge clock);
      #2;
    end
    for (int n = 0; n < NUM_INST; n++) begin
      make_inst(inst, pc, rs1, rs2);
      send_inst(inst, pc, rs1, rs2);
      gap = int'(rand32() % 8);
      gap = (gap < 5) ? 0 : (gap == 7) ? 6 : gap - 4;  // long gap drains the pipe
      repeat (gap) begin
        @(posedge clock);
        #2;
      end
    end
    while (retired < NUM_INST) @(posedge clock);
    repeat (8) @(posedge clock);  // catch duplicates
    $display("errors: %0d mismatches, %0d latency, %0d assertion; %0d of %0d retired",
             mismatches, late_count, dut_i.props_i.fail_count, retired, NUM_INST);
    if (mismatches == 0 && late_count == 0 && dut_i.props_i.fail_count == 0 &&
        retired == NUM_INST) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
